/* rtl/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and byte address width
`define LSU_XLEN 32

// reorder-buffer tag width, nick 0 means value present
`define LSU_NICK_W 4

// sign-extended immediate width
`define LSU_IMM_W 32

// word-address bits of the data memory
`define LSU_MEM_AW 10

// cycles from accepted load to response
`define LSU_MEM_LAT 2

`endif

/* rtl/lsu_pkg.sv */
`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]   data_t;
    typedef logic [`LSU_XLEN-1:0]   addr_t;
    typedef logic [`LSU_NICK_W-1:0] nick_t;
    typedef logic [`LSU_IMM_W-1:0]  imm_t;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        LEN_ONE  = 2'd0,
        LEN_TWO  = 2'd1,
        LEN_FOUR = 2'd2
    } acc_len_e;

    typedef struct packed {
        logic    valid;
        mem_op_e op;
        nick_t   nick;
        imm_t    imm;
        nick_t   rs1_nick;
        data_t   rs1_data;
        nick_t   rs2_nick;
        data_t   rs2_data;
    } dispatch_t;

    // shared by the execution and load result broadcasts
    typedef struct packed {
        logic  valid;
        nick_t nick;
        data_t data;
    } bcast_t;

    typedef struct packed {
        logic     valid;
        logic     is_store;
        logic     sign_ext;
        acc_len_e len;
        nick_t    nick;
        addr_t    addr;
        data_t    wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        nick_t nick;
        data_t rdata;
    } mem_rsp_t;

endpackage

/* rtl/lsb.sv */
`include "lsu_params.svh"

module lsb (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::bcast_t    ex_bcast,
    input  logic               commit_valid,
    input  lsu_pkg::nick_t     commit_nick,
    input  logic               mem_ready,
    input  lsu_pkg::mem_rsp_t  mem_rsp,
    output lsu_pkg::mem_req_t  mem_req,
    output lsu_pkg::bcast_t    lsb_bcast,
    output logic               full
);
    import lsu_pkg::*;

    localparam int NENT = 1 << `LSU_NICK_W;

    // per-entry control, operand 0 is rs1 and operand 1 is rs2
    logic [NENT-1:0]      occupied;
    logic [NENT-1:0]      committed;
    logic [NENT-1:0][1:0] src_rdy;
    logic [NENT-1:0][1:0] src_rdy_nx;
    logic [NENT-1:0]      is_st;

    // per-entry payload
    mem_op_e op       [NENT];
    imm_t    imm      [NENT];
    nick_t   src_nick [NENT][2];
    data_t   src_data [NENT][2];
    data_t   src_data_nx [NENT][2];

    logic  disp_en;
    nick_t disp_nick [2];
    data_t disp_val  [2];
    logic  disp_rdy  [2];
    data_t disp_data [2];

    logic  store_present;
    logic  st_found;
    logic  ld_found;
    nick_t st_idx;
    nick_t ld_idx;
    nick_t sel_idx;
    logic  issue_go;

    function automatic logic bcast_hit(bcast_t b, nick_t n);
        return b.valid && (b.nick == n);
    endfunction

    function automatic logic op_is_store(mem_op_e o);
        return (o == OP_SB) || (o == OP_SH) || (o == OP_SW);
    endfunction

    function automatic acc_len_e op_len(mem_op_e o);
        case (o)
            OP_LB, OP_LBU, OP_SB: return LEN_ONE;
            OP_LH, OP_LHU, OP_SH: return LEN_TWO;
            default:              return LEN_FOUR;
        endcase
    endfunction

    assign disp_en = dispatch.valid && (dispatch.op != OP_NONE);

    // operands at dispatch, picking up a broadcast seen in the same cycle
    always_comb begin
        disp_nick[0] = dispatch.rs1_nick;
        disp_nick[1] = dispatch.rs2_nick;
        disp_val[0]  = dispatch.rs1_data;
        disp_val[1]  = dispatch.rs2_data;
        for (int j = 0; j < 2; j++) begin
            disp_rdy[j]  = 1'b1;
            disp_data[j] = disp_val[j];
            if (disp_nick[j] != '0) begin
                if (bcast_hit(ex_bcast, disp_nick[j])) begin
                    disp_data[j] = ex_bcast.data;
                end else if (bcast_hit(lsb_bcast, disp_nick[j])) begin
                    disp_data[j] = lsb_bcast.data;
                end else begin
                    disp_rdy[j] = 1'b0;
                end
            end
        end
    end

    // wakeup from both broadcasts, also feeds selection as a bypass
    always_comb begin
        for (int i = 0; i < NENT; i++) begin
            is_st[i] = op_is_store(op[i]);
            for (int j = 0; j < 2; j++) begin
                src_rdy_nx[i][j]  = src_rdy[i][j];
                src_data_nx[i][j] = src_data[i][j];
                if (occupied[i] && !src_rdy[i][j]) begin
                    if (bcast_hit(ex_bcast, src_nick[i][j])) begin
                        src_rdy_nx[i][j]  = 1'b1;
                        src_data_nx[i][j] = ex_bcast.data;
                    end else if (bcast_hit(lsb_bcast, src_nick[i][j])) begin
                        src_rdy_nx[i][j]  = 1'b1;
                        src_data_nx[i][j] = lsb_bcast.data;
                    end
                end
            end
        end
    end

    assign store_present = |(occupied & is_st);

    // descending scan so the lowest ready nick wins
    always_comb begin
        st_found = 1'b0;
        ld_found = 1'b0;
        st_idx   = '0;
        ld_idx   = '0;
        for (int i = NENT - 1; i >= 1; i--) begin
            if (occupied[i] && is_st[i] && committed[i] && (&src_rdy_nx[i])) begin
                st_found = 1'b1;
                st_idx   = nick_t'(i);
            end
            if (occupied[i] && !is_st[i] && src_rdy_nx[i][0]) begin
                ld_found = 1'b1;
                ld_idx   = nick_t'(i);
            end
        end
    end

    assign sel_idx  = st_found ? st_idx : ld_idx;
    assign issue_go = mem_ready && !mem_req.valid && (st_found || (ld_found && !store_present));

    // entry 0 is never allocated
    assign full = &occupied[NENT-1:1];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            occupied        <= '0;
            committed       <= '0;
            src_rdy         <= '0;
            mem_req.valid   <= 1'b0;
            lsb_bcast.valid <= 1'b0;
        end else begin
            src_rdy <= src_rdy_nx;
            if (commit_valid && occupied[commit_nick] && is_st[commit_nick]) begin
                committed[commit_nick] <= 1'b1;
            end
            mem_req.valid <= issue_go;
            if (issue_go) begin
                occupied[sel_idx] <= 1'b0;
                mem_req.is_store  <= is_st[sel_idx];
                mem_req.sign_ext  <= (op[sel_idx] == OP_LB) || (op[sel_idx] == OP_LH);
                mem_req.len       <= op_len(op[sel_idx]);
                mem_req.nick      <= sel_idx;
                mem_req.addr      <= addr_t'(src_data_nx[sel_idx][0] + imm[sel_idx]);
                mem_req.wdata     <= src_data_nx[sel_idx][1];
            end
            if (disp_en) begin
                occupied[dispatch.nick]  <= 1'b1;
                committed[dispatch.nick] <= 1'b0;
                src_rdy[dispatch.nick]   <= {disp_rdy[1], disp_rdy[0]};
            end
            // load result goes out one cycle after the memory response
            lsb_bcast.valid <= mem_rsp.valid;
            if (mem_rsp.valid) begin
                lsb_bcast.nick <= mem_rsp.nick;
                lsb_bcast.data <= mem_rsp.rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        src_data <= src_data_nx;
        if (disp_en) begin
            op[dispatch.nick]          <= dispatch.op;
            imm[dispatch.nick]         <= dispatch.imm;
            src_nick[dispatch.nick][0] <= dispatch.rs1_nick;
            src_nick[dispatch.nick][1] <= dispatch.rs2_nick;
            src_data[dispatch.nick][0] <= disp_data[0];
            src_data[dispatch.nick][1] <= disp_data[1];
        end
    end

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n || flush)
        disp_en |-> !occupied[dispatch.nick])
        else $error("dispatch into occupied entry %0d", dispatch.nick);

    a_req_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.valid |-> mem_ready)
        else $error("memory request raised while memory busy");

    a_no_nick_zero: assert property (@(posedge clk) disable iff (!rst_n)
        disp_en |-> dispatch.nick != '0)
        else $error("dispatch with nick 0");

endmodule

/* rtl/dmem.sv */
`include "lsu_params.svh"

module dmem (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  lsu_pkg::mem_req_t mem_req,
    output logic              mem_ready,
    output lsu_pkg::mem_rsp_t mem_rsp
);
    import lsu_pkg::*;

    localparam int WORDS = 1 << `LSU_MEM_AW;
    localparam int CNT_W = $clog2(`LSU_MEM_LAT + 1);

    data_t mem [WORDS];

    logic [`LSU_MEM_AW-1:0] word_idx;
    logic [1:0]             lane;
    logic [3:0]             be;
    data_t                  wword;
    logic                   accept;

    // single load in flight while busy
    logic [CNT_W-1:0] busy_cnt;
    nick_t            hold_nick;
    logic [1:0]       hold_lane;
    acc_len_e         hold_len;
    logic             hold_sign;
    data_t            hold_word;

    function automatic data_t extend(data_t w, logic [1:0] ln, acc_len_e len, logic sgn);
        data_t sh;
        sh = w >> (8 * ln);
        case (len)
            LEN_ONE: return {{(`LSU_XLEN-8){sgn & sh[7]}}, sh[7:0]};
            LEN_TWO: return {{(`LSU_XLEN-16){sgn & sh[15]}}, sh[15:0]};
            default: return w;
        endcase
    endfunction

    // upper address bits wrap around the memory size
    assign word_idx  = mem_req.addr[`LSU_MEM_AW+1:2];
    assign lane      = mem_req.addr[1:0];
    assign mem_ready = (busy_cnt == '0);
    assign accept    = mem_req.valid && mem_ready;

    // replicate the data so every lane sees it, enables pick the lane
    always_comb begin
        case (mem_req.len)
            LEN_ONE: begin
                be    = 4'b0001 << lane;
                wword = {4{mem_req.wdata[7:0]}};
            end
            LEN_TWO: begin
                be    = 4'b0011 << lane;
                wword = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wword = mem_req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && mem_req.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem[word_idx][8*b +: 8] <= wword[8*b +: 8];
                end
            end
        end
        if (accept && !mem_req.is_store) begin
            hold_word <= mem[word_idx];
            hold_nick <= mem_req.nick;
            hold_lane <= lane;
            hold_len  <= mem_req.len;
            hold_sign <= mem_req.sign_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy_cnt      <= '0;
            mem_rsp.valid <= 1'b0;
        end else begin
            mem_rsp.valid <= 1'b0;
            if (accept && !mem_req.is_store) begin
                busy_cnt <= CNT_W'(`LSU_MEM_LAT);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            // last busy cycle delivers the extended word
            if (busy_cnt == CNT_W'(1)) begin
                mem_rsp.valid <= 1'b1;
                mem_rsp.nick  <= hold_nick;
                mem_rsp.rdata <= extend(hold_word, hold_lane, hold_len, hold_sign);
            end
        end
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> (mem_req.len != LEN_TWO  || !mem_req.addr[0]) &&
                   (mem_req.len != LEN_FOUR || mem_req.addr[1:0] == 2'b00))
        else $error("misaligned access at %h", mem_req.addr);

endmodule

/* rtl/lsu_top.sv */
module lsu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::bcast_t    ex_bcast,
    input  logic               commit_valid,
    input  lsu_pkg::nick_t     commit_nick,
    output lsu_pkg::bcast_t    lsb_bcast,
    output logic               full
);
    import lsu_pkg::*;

    // buffer to memory request and response path
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     mem_ready;

    lsb u_lsb (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .dispatch     (dispatch),
        .ex_bcast     (ex_bcast),
        .commit_valid (commit_valid),
        .commit_nick  (commit_nick),
        .mem_ready    (mem_ready),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .lsb_bcast    (lsb_bcast),
        .full         (full)
    );

    dmem u_dmem (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .mem_req   (mem_req),
        .mem_ready (mem_ready),
        .mem_rsp   (mem_rsp)
    );

endmodule

/* dv/lsu_tb.sv */
`include "lsu_params.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        S_DISP, S_BCAST, S_COMMIT, S_FLUSH, S_QUIET, S_FULL
    } step_kind_e;

    // bcast carries d.nick and d.rs1_data and commit carries d.nick
    // cnt holds a cycle count or the expected full level
    typedef struct packed {
        step_kind_e  kind;
        int unsigned row;
        int unsigned cnt;
        dispatch_t   d;
    } step_t;

    // lat of 0 means no latency check
    typedef struct packed {
        int unsigned row;
        nick_t       nick;
        data_t       value;
        int unsigned lat;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      flush;
    dispatch_t dispatch;
    bcast_t    ex_bcast;
    logic      commit_valid;
    nick_t     commit_nick;
    bcast_t    lsb_bcast;
    logic      full;

    step_t   steps [$];
    expect_t expects [$];
    string   row_names [$];
    data_t   model_mem [int];

    logic  got_valid [16];
    data_t got_data  [16];
    int    got_edge  [16];
    int    rx_count;
    int    cyc;
    int    limit;
    int    bcast_edge;
    int    row_err;
    int    total_err;
    int    n_checks;

    lsu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .dispatch     (dispatch),
        .ex_bcast     (ex_bcast),
        .commit_valid (commit_valid),
        .commit_nick  (commit_nick),
        .lsb_bcast    (lsb_bcast),
        .full         (full)
    );

    always #10 clk = ~clk;

    // edge counter and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit != 0 && cyc >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // got_edge is the edge that raised valid
    always @(posedge clk) begin
        if (rst_n && lsb_bcast.valid) begin
            got_valid[lsb_bcast.nick] <= 1'b1;
            got_data[lsb_bcast.nick]  <= lsb_bcast.data;
            got_edge[lsb_bcast.nick]  <= cyc;
            rx_count                  <= rx_count + 1;
        end
    end

    function automatic int byte_count(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    function automatic int word_of(addr_t a);
        return int'((a >> 2) % (1 << `LSU_MEM_AW));
    endfunction

    // byte-by-byte reference memory
    function void model_write(mem_op_e op, addr_t addr, data_t data);
        addr_t a;
        data_t tmp;
        for (int k = 0; k < byte_count(op); k++) begin
            a = addr + k;
            tmp = model_mem.exists(word_of(a)) ? model_mem[word_of(a)] : 'x;
            tmp[8*a[1:0] +: 8] = data[8*k +: 8];
            model_mem[word_of(a)] = tmp;
        end
    endfunction

    function data_t model_read(mem_op_e op, addr_t addr);
        addr_t a;
        data_t tmp;
        data_t raw;
        raw = '0;
        for (int k = 0; k < byte_count(op); k++) begin
            a = addr + k;
            tmp = model_mem[word_of(a)];
            raw[8*k +: 8] = tmp[8*a[1:0] +: 8];
        end
        if (op == OP_LB && raw[7]) raw[31:8] = '1;
        if (op == OP_LH && raw[15]) raw[31:16] = '1;
        return raw;
    endfunction

    function void add_disp(mem_op_e op, nick_t nick, imm_t imm, nick_t n1, data_t v1,
                           nick_t n2, data_t v2);
        step_t s;
        s = '0;
        s.kind = S_DISP;
        s.row = row_names.size() - 1;
        s.d = '{valid: 1'b1, op: op, nick: nick, imm: imm, rs1_nick: n1, rs1_data: v1,
                rs2_nick: n2, rs2_data: v2};
        steps.push_back(s);
    endfunction

    function void add_ctl(step_kind_e kind, nick_t nick, data_t data, int unsigned cnt);
        step_t s;
        s = '0;
        s.kind = kind;
        s.row = row_names.size() - 1;
        s.cnt = cnt;
        s.d.nick = nick;
        s.d.rs1_data = data;
        steps.push_back(s);
    endfunction

    function void add_expect(nick_t nick, data_t value, int unsigned lat);
        expects.push_back('{row: row_names.size() - 1, nick: nick, value: value, lat: lat});
    endfunction

    function void add_store(mem_op_e op, nick_t nick, addr_t addr, data_t data);
        add_disp(op, nick, '0, '0, addr, '0, data);
        model_write(op, addr, data);
    endfunction

    function void add_load(mem_op_e op, nick_t nick, addr_t addr);
        add_disp(op, nick, '0, '0, addr, '0, '0);
        add_expect(nick, model_read(op, addr), 0);
    endfunction

    function void build_table();
        data_t w;
        data_t b;
        data_t h;
        row_names.push_back("word_round_trip");
        add_store(OP_SW, 1, 32'h100, $urandom());
        add_ctl(S_COMMIT, 1, '0, 0);
        add_load(OP_LW, 2, 32'h100);

        row_names.push_back("subword_lanes");
        w = $urandom();
        b = $urandom() | 32'h80;
        h = $urandom() | 32'h8000;
        add_store(OP_SW, 1, 32'h204, w);
        add_store(OP_SB, 2, 32'h205, b);
        add_store(OP_SH, 3, 32'h206, h);
        add_ctl(S_COMMIT, 1, '0, 0);
        add_ctl(S_COMMIT, 2, '0, 0);
        add_ctl(S_COMMIT, 3, '0, 0);
        add_load(OP_LB, 4, 32'h205);
        add_load(OP_LBU, 5, 32'h205);
        add_load(OP_LH, 6, 32'h206);
        add_load(OP_LHU, 7, 32'h206);
        add_load(OP_LW, 8, 32'h204);
        add_load(OP_LB, 9, 32'h204);

        // base arrives late on the execution broadcast
        row_names.push_back("exec_wakeup");
        add_store(OP_SW, 1, 32'h3f0, $urandom());
        add_ctl(S_COMMIT, 1, '0, 0);
        add_disp(OP_LW, 3, 32'd4, 9, '0, '0, '0);
        add_ctl(S_QUIET, 0, '0, 10);
        add_ctl(S_BCAST, 9, 32'h3ec, 0);
        add_expect(3, model_read(OP_LW, 32'h3f0), 4);

        // pointer at 0x080 leads to 0x1c0
        row_names.push_back("load_chain");
        add_store(OP_SW, 1, 32'h080, 32'h1c0);
        add_store(OP_SW, 2, 32'h1c0, $urandom());
        add_ctl(S_COMMIT, 1, '0, 0);
        add_ctl(S_COMMIT, 2, '0, 0);
        add_load(OP_LW, 5, 32'h080);
        add_disp(OP_LW, 6, '0, 5, '0, '0, '0);
        add_expect(6, model_read(OP_LW, 32'h1c0), 0);

        row_names.push_back("store_waits_commit");
        add_store(OP_SW, 4, 32'h2a8, $urandom());
        add_load(OP_LW, 5, 32'h2a8);
        add_ctl(S_QUIET, 0, '0, 12);
        add_ctl(S_COMMIT, 4, '0, 0);

        // every load waits on nick 1 until its broadcast after the flush
        row_names.push_back("full_and_flush");
        for (int n = 1; n < 16; n++) begin
            add_disp(OP_LW, nick_t'(n), '0, 1, '0, '0, '0);
        end
        add_ctl(S_FULL, 0, '0, 1);
        add_ctl(S_FLUSH, 0, '0, 0);
        add_ctl(S_FULL, 0, '0, 0);
        add_ctl(S_BCAST, 1, 32'h100, 0);
        add_ctl(S_QUIET, 0, '0, 40);
    endfunction

    task automatic apply_step(input step_t s, input string name);
        case (s.kind)
            S_DISP: begin
                dispatch = s.d;
                @(negedge clk);
                dispatch = '0;
            end
            S_BCAST: begin
                ex_bcast = '{valid: 1'b1, nick: s.d.nick, data: s.d.rs1_data};
                bcast_edge = cyc + 1;
                @(negedge clk);
                ex_bcast = '0;
            end
            S_COMMIT: begin
                commit_valid = 1'b1;
                commit_nick = s.d.nick;
                @(negedge clk);
                commit_valid = 1'b0;
            end
            S_FLUSH: begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            S_QUIET: begin
                repeat (s.cnt) @(negedge clk);
                n_checks++;
                assert (rx_count == 0) else begin
                    $display("%s: a load result was broadcast while none was expected", name);
                    row_err++;
                end
            end
            S_FULL: begin
                n_checks++;
                assert (full == s.cnt[0]) else begin
                    $display("CHECK FAILED %s full expected %0d actual %0d",
                             name, s.cnt[0], full);
                    row_err++;
                end
            end
        endcase
    endtask

    task automatic check_expect(input expect_t e, input string name);
        int waited;
        waited = 0;
        while (!got_valid[e.nick] && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        n_checks++;
        assert (got_valid[e.nick]) else begin
            $display("%s: no load result for nick %0d within 40 cycles", name, e.nick);
            row_err++;
        end
        if (got_valid[e.nick]) begin
            n_checks++;
            assert (got_data[e.nick] == e.value) else begin
                $display("CHECK FAILED %s nick %0d expected %h actual %h",
                         name, e.nick, e.value, got_data[e.nick]);
                row_err++;
            end
            if (e.lat != 0) begin
                n_checks++;
                assert (got_edge[e.nick] - bcast_edge == int'(e.lat)) else begin
                    $display("CHECK FAILED %s latency expected %0d actual %0d",
                             name, e.lat, got_edge[e.nick] - bcast_edge);
                    row_err++;
                end
            end
        end
    endtask

    initial begin
        int si;
        int ei;
        void'($urandom(32'h733e));
        clk = 1'b0;
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch = '0;
        ex_bcast = '0;
        commit_valid = 1'b0;
        commit_nick = '0;
        cyc = 0;
        limit = 0;
        rx_count = 0;
        total_err = 0;
        n_checks = 0;
        build_table();
        limit = 60 * row_names.size() + 200;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        n_checks++;
        assert (!full && !lsb_bcast.valid) else begin
            $display("outputs not idle after reset");
            total_err++;
        end
        si = 0;
        ei = 0;
        for (int r = 0; r < row_names.size(); r++) begin
            row_err = 0;
            rx_count = 0;
            for (int i = 0; i < 16; i++) got_valid[i] = 1'b0;
            while (si < steps.size() && steps[si].row == r) begin
                apply_step(steps[si], row_names[r]);
                si++;
            end
            while (ei < expects.size() && expects[ei].row == r) begin
                check_expect(expects[ei], row_names[r]);
                ei++;
            end
            // let the buffer drain before the next row
            repeat (4) @(negedge clk);
            $display("test %s %s", row_names[r], (row_err == 0) ? "ok" : "errors");
            total_err += row_err;
        end
        $display("tests %0d, checks %0d, errors %0d", row_names.size(), n_checks, total_err);
        if (total_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsb.sv
rtl/dmem.sv
rtl/lsu_top.sv
dv/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_pkg.sv
      - rtl/lsb.sv
      - rtl/dmem.sv
      - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/lsu_tb.sv
